/* bus_decode/main_bus_decode.sv */
/* Main bus decoder
   Registered chip selects per queued access, memory wait and in-order read return */

module main_bus_decode (
    input  logic                clk,
    input  logic                rst,
    // Request FIFO
    input  logic                empty,
    input  main_bus_pkg::req_t  pop_data,
    output logic                pop,
    // Chip selects
    output logic                rom_cs,
    output logic                ram_cs,
    output logic                vram_cs,
    output logic                char_cs,
    output logic                pal_cs,
    output logic                obj_cs,
    // Memory bus
    output logic [12:1]         bus_addr,
    output main_bus_pkg::word_t bus_dout,
    output logic                bus_rnw,
    output logic [1:0]          bus_dsn,
    input  main_bus_pkg::word_t rom_data,
    input  logic                rom_ok,
    input  main_bus_pkg::word_t ram_data,  // RAM and VRAM
    input  logic                ram_ok,
    input  main_bus_pkg::word_t char_dout,
    input  main_bus_pkg::word_t pal_dout,
    input  main_bus_pkg::word_t obj_dout,
    // Cabinet inputs
    input  main_bus_pkg::byte_t joystick1,
    input  main_bus_pkg::byte_t joystick2,
    input  logic [1:0]          start_button,
    input  logic [1:0]          coin_input,
    input  logic                service,
    input  main_bus_pkg::byte_t dipsw,
    // Cipher keys
    input  logic                key_we,
    input  logic [2:0]          key_addr,
    input  main_bus_pkg::word_t key_data,
    input  logic                dec_en,
    // Completion
    output logic                done,
    output main_bus_pkg::word_t rdata
);

    typedef enum logic [1:0] {
        IDLE,
        SEL,
        WAIT,
        DONE
    } state_t;

    state_t                state;
    main_bus_pkg::req_t    cur;
    main_bus_pkg::addr_t   new_addr;
    main_bus_pkg::addr_t   cur_addr;
    main_bus_pkg::region_e new_reg;
    main_bus_pkg::region_e cur_reg;
    main_bus_pkg::word_t   rom_dec;
    main_bus_pkg::word_t   rd_mux;
    main_bus_pkg::byte_t   sys_byte;
    main_bus_pkg::byte_t   cab_dout;
    logic                  cur_op;
    logic                  slow_cs;
    logic                  mem_ready;
    logic                  finish;

    // Fields of the head entry and of the access in progress
    assign new_addr = pop_data[main_bus_pkg::REQ_ADDR_LSB +: $bits(main_bus_pkg::addr_t)];
    assign new_reg  = main_bus_pkg::region_e'(
                      pop_data[main_bus_pkg::REQ_REG_LSB +: $bits(main_bus_pkg::region_e)]);
    assign cur_addr = cur[main_bus_pkg::REQ_ADDR_LSB +: $bits(main_bus_pkg::addr_t)];
    assign cur_reg  = main_bus_pkg::region_e'(
                      cur[main_bus_pkg::REQ_REG_LSB +: $bits(main_bus_pkg::region_e)]);
    assign cur_op   = cur[main_bus_pkg::REQ_OP_BIT];

    assign bus_addr = cur_addr[12:1];
    assign bus_dout = cur[main_bus_pkg::REQ_DATA_LSB +: $bits(main_bus_pkg::word_t)];
    assign bus_rnw  = cur[main_bus_pkg::REQ_RNW_BIT];
    assign bus_dsn  = cur[main_bus_pkg::REQ_DSN_LSB +: 2];

    assign pop  = (state == IDLE) && !empty;
    assign done = (state == DONE);

    // Only ROM, RAM and VRAM have a ready signal
    assign slow_cs   = rom_cs | ram_cs | vram_cs;
    assign mem_ready = (rom_cs & rom_ok) | ((ram_cs | vram_cs) & ram_ok);
    assign finish    = ((state == SEL) && (!slow_cs || mem_ready)) ||
                       ((state == WAIT) && mem_ready);

    rom_decoder u_rom_dec (
        .clk      (clk),
        .rst      (rst),
        .key_we   (key_we),
        .key_addr (key_addr),
        .key_data (key_data),
        .dec_en   (dec_en),
        .op_fetch (cur_op),
        .addr_lo  (cur_addr[3:1]),
        .enc      (rom_data),
        .dec      (rom_dec)
    );

    // Cabinet inputs
    assign sys_byte = {3'b000, start_button, coin_input, service};

    always_comb begin
        case (cur_addr[2:1])
            2'd0:    cab_dout = joystick1;
            2'd1:    cab_dout = joystick2;
            2'd2:    cab_dout = sys_byte;
            default: cab_dout = dipsw;
        endcase
    end

    always_comb begin
        if (ram_cs || vram_cs) begin
            rd_mux = ram_data;
        end else if (rom_cs) begin
            rd_mux = rom_dec;
        end else if (char_cs) begin
            rd_mux = char_dout;
        end else if (pal_cs) begin
            rd_mux = pal_dout;
        end else if (obj_cs) begin
            rd_mux = obj_dout;
        end else if (cur_reg == main_bus_pkg::REG_IO) begin
            rd_mux = {8'hff, cab_dout};
        end else begin
            rd_mux = 16'hffff;  // unmapped
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, obj_cs} <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (pop) begin
                        rom_cs  <= new_reg == main_bus_pkg::REG_MEM && new_addr[18:17] != 2'b11;
                        ram_cs  <= new_reg == main_bus_pkg::REG_MEM && new_addr[18:17] == 2'b11;
                        vram_cs <= new_reg == main_bus_pkg::REG_SCR && !new_addr[16];
                        char_cs <= new_reg == main_bus_pkg::REG_SCR && new_addr[16];
                        pal_cs  <= new_reg == main_bus_pkg::REG_PAL;
                        obj_cs  <= new_reg == main_bus_pkg::REG_OBJ;
                        state   <= SEL;
                    end
                end
                SEL, WAIT: begin
                    if (finish) begin
                        {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, obj_cs} <= '0;
                        state <= DONE;
                    end else begin
                        state <= WAIT;
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Access capture and read data latch
    always_ff @(posedge clk) begin
        if (pop) begin
            cur <= pop_data;
        end
        if (finish) begin
            rdata <= rd_mux;
        end
    end

endmodule

/* bus_decode/rom_decoder.sv */
/* ROM word decryption
   Eight-entry key table, XOR with the key or its byte swap by fetch type */

module rom_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                key_we,
    input  logic [2:0]          key_addr,
    input  main_bus_pkg::word_t key_data,
    input  logic                dec_en,
    input  logic                op_fetch,
    input  logic [3:1]          addr_lo,
    input  main_bus_pkg::word_t enc,
    output main_bus_pkg::word_t dec
);

    main_bus_pkg::word_t keys [main_bus_pkg::KEY_COUNT];
    main_bus_pkg::word_t key;
    main_bus_pkg::word_t key_swap;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < main_bus_pkg::KEY_COUNT; k++) begin
                keys[k] <= '0;
            end
        end else if (key_we) begin
            keys[key_addr] <= key_data;
        end
    end

    // Key picked by the word address within each 16-byte line
    assign key      = keys[addr_lo];
    assign key_swap = {key[7:0], key[15:8]};

    always_comb begin
        if (!dec_en) begin
            dec = enc;
        end else if (op_fetch) begin
            dec = enc ^ key;
        end else begin
            // data reads use the swapped key
            dec = enc ^ key_swap;
        end
    end

endmodule

/* common/main_bus_pkg.sv */
/* Main CPU bus package
   Shared widths, mapper region codes and the packed layout of a queued request */

package main_bus_pkg;

    // Word address of the 68000 bus, A0 is replaced by the data strobes
    typedef logic [23:1] addr_t;
    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;

    // Mapper regions, in priority order
    typedef enum logic [2:0] {
        REG_MEM  = 3'd0,
        REG_SCR  = 3'd1,
        REG_PAL  = 3'd2,
        REG_OBJ  = 3'd3,
        REG_IO   = 3'd4,
        REG_NONE = 3'd5
    } region_e;

    localparam int NUM_REGIONS = 5;
    localparam int KEY_COUNT   = 8;

    // Request fields, from the low end up
    // {addr, wdata, rnw, dsn, op_fetch, region}
    localparam int REQ_REG_LSB  = 0;
    localparam int REQ_OP_BIT   = REQ_REG_LSB + $bits(region_e);
    localparam int REQ_DSN_LSB  = REQ_OP_BIT + 1;
    localparam int REQ_RNW_BIT  = REQ_DSN_LSB + 2;
    localparam int REQ_DATA_LSB = REQ_RNW_BIT + 1;
    localparam int REQ_ADDR_LSB = REQ_DATA_LSB + $bits(word_t);
    localparam int REQ_W        = REQ_ADDR_LSB + $bits(addr_t);

    // One FIFO entry
    typedef logic [REQ_W-1:0] req_t;

endpackage

/* flist.f */
common/main_bus_pkg.sv
bus_decode/rom_decoder.sv
bus_decode/main_bus_decode.sv
src/main_mapper.sv
src/req_fifo.sv
src/main_bus_top.sv
tb/main_bus_sva.sv
tb/main_bus_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the main bus testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module main_bus_tb -f flist.f \
    -o main_bus_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/main_bus_sim > sim.log 2>&1 || echo "TB FAILED" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0

/* src/main_bus_top.sv */
/* Main CPU bus top level
   Mapper, request FIFO and bus decoder */

module main_bus_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    // Bus master
    input  logic                req,
    input  main_bus_pkg::addr_t addr,
    input  main_bus_pkg::word_t wdata,
    input  logic                rnw,
    input  logic [1:0]          dsn,
    input  logic                op_fetch,
    output logic                bus_free,
    // Configuration
    input  logic                cfg_we,
    input  logic [3:0]          cfg_addr,
    input  main_bus_pkg::byte_t cfg_data,
    input  logic                key_we,
    input  logic [2:0]          key_addr,
    input  main_bus_pkg::word_t key_data,
    input  logic                dec_en,
    // Memories
    output logic                rom_cs,
    output logic                ram_cs,
    output logic                vram_cs,
    output logic                char_cs,
    output logic                pal_cs,
    output logic                obj_cs,
    output logic [12:1]         bus_addr,
    output main_bus_pkg::word_t bus_dout,
    output logic                bus_rnw,
    output logic [1:0]          bus_dsn,
    input  main_bus_pkg::word_t rom_data,
    input  logic                rom_ok,
    input  main_bus_pkg::word_t ram_data,
    input  logic                ram_ok,
    input  main_bus_pkg::word_t char_dout,
    input  main_bus_pkg::word_t pal_dout,
    input  main_bus_pkg::word_t obj_dout,
    // Cabinet
    input  main_bus_pkg::byte_t joystick1,
    input  main_bus_pkg::byte_t joystick2,
    input  logic [1:0]          start_button,
    input  logic [1:0]          coin_input,
    input  logic                service,
    input  main_bus_pkg::byte_t dipsw,
    // Completion
    output logic                done,
    output main_bus_pkg::word_t rdata
);

    logic               push;
    logic               pop;
    logic               full;
    logic               empty;
    main_bus_pkg::req_t push_data;
    main_bus_pkg::req_t pop_data;

    assign bus_free = !full;

    main_mapper u_mapper (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .addr      (addr),
        .wdata     (wdata),
        .rnw       (rnw),
        .dsn       (dsn),
        .op_fetch  (op_fetch),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .push      (push),
        .push_data (push_data)
    );

    req_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    main_bus_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .empty        (empty),
        .pop_data     (pop_data),
        .pop          (pop),
        .rom_cs       (rom_cs),
        .ram_cs       (ram_cs),
        .vram_cs      (vram_cs),
        .char_cs      (char_cs),
        .pal_cs       (pal_cs),
        .obj_cs       (obj_cs),
        .bus_addr     (bus_addr),
        .bus_dout     (bus_dout),
        .bus_rnw      (bus_rnw),
        .bus_dsn      (bus_dsn),
        .rom_data     (rom_data),
        .rom_ok       (rom_ok),
        .ram_data     (ram_data),
        .ram_ok       (ram_ok),
        .char_dout    (char_dout),
        .pal_dout     (pal_dout),
        .obj_dout     (obj_dout),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dipsw        (dipsw),
        .key_we       (key_we),
        .key_addr     (key_addr),
        .key_data     (key_data),
        .dec_en       (dec_en),
        .done         (done),
        .rdata        (rdata)
    );

endmodule

/* src/main_mapper.sv */
/* Main bus mapper
   Programmable region table, priority address match and request enqueue */

module main_mapper (
    input  logic                clk,
    input  logic                rst,
    // Bus master strobes
    input  logic                req,
    input  main_bus_pkg::addr_t addr,
    input  main_bus_pkg::word_t wdata,
    input  logic                rnw,
    input  logic [1:0]          dsn,
    input  logic                op_fetch,
    // Region table writes
    input  logic                cfg_we,
    input  logic [3:0]          cfg_addr,
    input  main_bus_pkg::byte_t cfg_data,
    // FIFO side
    output logic                push,
    output main_bus_pkg::req_t  push_data
);

    main_bus_pkg::byte_t   base [main_bus_pkg::NUM_REGIONS];
    main_bus_pkg::byte_t   mask [main_bus_pkg::NUM_REGIONS];
    main_bus_pkg::region_e hit_reg;
    logic [2:0]            cfg_sel;
    logic                  cfg_hit;

    // Even address is the base, odd the mask
    assign cfg_sel = cfg_addr[3:1];
    assign cfg_hit = cfg_we && (int'(cfg_sel) < main_bus_pkg::NUM_REGIONS);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < main_bus_pkg::NUM_REGIONS; r++) begin
                base[r] <= '0;
                mask[r] <= '0;
            end
        end else if (cfg_hit) begin
            if (cfg_addr[0]) begin
                mask[cfg_sel] <= cfg_data;
            end else begin
                base[cfg_sel] <= cfg_data;
            end
        end
    end

    // Lowest region number wins, so scan from the top down
    always_comb begin
        hit_reg = main_bus_pkg::REG_NONE;
        for (int r = main_bus_pkg::NUM_REGIONS - 1; r >= 0; r--) begin
            if (((addr[23:16] ^ base[r]) & mask[r]) == 8'h00) begin
                hit_reg = main_bus_pkg::region_e'(r[2:0]);
            end
        end
    end

    // Push follows the strobe by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            push <= 1'b0;
        end else begin
            push <= req;
        end
    end

    // Entry is packed with the resolved region
    always_ff @(posedge clk) begin
        if (req) begin
            push_data[main_bus_pkg::REQ_ADDR_LSB +: $bits(main_bus_pkg::addr_t)] <= addr;
            push_data[main_bus_pkg::REQ_DATA_LSB +: $bits(main_bus_pkg::word_t)] <= wdata;
            push_data[main_bus_pkg::REQ_RNW_BIT]                               <= rnw;
            push_data[main_bus_pkg::REQ_DSN_LSB +: 2]                          <= dsn;
            push_data[main_bus_pkg::REQ_OP_BIT]                                <= op_fetch;
            push_data[main_bus_pkg::REQ_REG_LSB +: $bits(main_bus_pkg::region_e)] <= hit_reg;
        end
    end

endmodule

/* src/req_fifo.sv */
/* Request FIFO
   Circular buffer with first-word fall-through read and full/empty levels */

module req_fifo #(
    parameter int DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  main_bus_pkg::req_t push_data,
    input  logic               pop,
    output main_bus_pkg::req_t pop_data,
    output logic               full,
    output logic               empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    main_bus_pkg::req_t mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    // Also counts the entry being written now, the mapper pushes a cycle late
    assign full    = (count == CNT_W'(DEPTH)) || (push && count == CNT_W'(DEPTH - 1));
    assign do_pop  = pop && !empty;
    // A full buffer still takes a push when the head leaves in the same cycle
    assign do_push = push && (count != CNT_W'(DEPTH) || do_pop);

    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* tb/main_bus_sva.sv */
/* Bus decoder assertions
   Chip selects exclusive and idle on done, done a single-cycle pulse */

module main_bus_sva (
    input logic clk,
    input logic rst,
    input logic rom_cs,
    input logic ram_cs,
    input logic vram_cs,
    input logic char_cs,
    input logic pal_cs,
    input logic obj_cs,
    input logic done
);

    logic [5:0] cs_vec;

    assign cs_vec = {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, obj_cs};

    a_one_select: assert property (@(posedge clk) disable iff (rst) $onehot0(cs_vec))
        else $error("more than one chip select high");

    a_idle_on_done: assert property (@(posedge clk) disable iff (rst)
        done |-> (cs_vec == 6'b000000))
        else $error("chip select high in the done cycle");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done lasted more than one cycle");

endmodule

bind main_bus_decode main_bus_sva u_sva (
    .clk     (clk),
    .rst     (rst),
    .rom_cs  (rom_cs),
    .ram_cs  (ram_cs),
    .vram_cs (vram_cs),
    .char_cs (char_cs),
    .pal_cs  (pal_cs),
    .obj_cs  (obj_cs),
    .done    (done)
);

/* tb/main_bus_tb.sv */
/* Main bus testbench
   Memory models, table of accesses with expected results, in-order checks on done */

module main_bus_tb;

    localparam int N_MAX = 40;
    localparam main_bus_pkg::byte_t JOY1 = 8'h3c;
    localparam main_bus_pkg::byte_t JOY2 = 8'hc3;
    localparam main_bus_pkg::byte_t DIPS = 8'ha5;
    localparam logic [1:0] START = 2'b10;
    localparam logic [1:0] COIN  = 2'b01;
    localparam logic       SERV  = 1'b1;

    logic clk, rst, req, rnw, op_fetch, bus_free, cfg_we, key_we, dec_en;
    main_bus_pkg::addr_t addr;
    main_bus_pkg::word_t wdata, key_data, bus_dout, rdata;
    logic [1:0] dsn, bus_dsn, start_button, coin_input;
    logic [3:0] cfg_addr;
    logic [2:0] key_addr;
    main_bus_pkg::byte_t cfg_data, joystick1, joystick2, dipsw;
    logic rom_cs, ram_cs, vram_cs, char_cs, pal_cs, obj_cs, bus_rnw, service, done;
    logic [12:1] bus_addr;
    main_bus_pkg::word_t rom_data, ram_data, char_dout, pal_dout, obj_dout;
    logic rom_ok, ram_ok;

    // Region table as programmed in region order
    // I/O mask leaves bit 23 open so page 0x44 also matches the object region
    main_bus_pkg::byte_t cfg_base [5] = '{8'h00, 8'h40, 8'h84, 8'h44, 8'hc4};
    main_bus_pkg::byte_t cfg_mask [5] = '{8'hf0, 8'hfe, 8'hff, 8'hff, 8'h7f};

    // Access table and expected results
    logic [23:0]         t_addr [N_MAX];
    logic                t_rnw [N_MAX];
    main_bus_pkg::word_t t_wdata [N_MAX];
    logic [1:0]          t_dsn [N_MAX];
    logic                t_op [N_MAX];
    logic                t_dec [N_MAX];
    logic                t_burst [N_MAX];
    main_bus_pkg::word_t e_rdata [N_MAX];
    logic [5:0]          e_cs [N_MAX];
    int n_tests = 0;

    main_bus_pkg::word_t ram_shadow [4096];
    main_bus_pkg::word_t vram_shadow [4096];
    main_bus_pkg::word_t ram_mem [4096];
    main_bus_pkg::word_t vram_mem [4096];

    int pending [$];
    int errors = 0;
    int pass_count = 0;
    int fail_count = 0;
    int done_count = 0;
    logic [5:0] seen_cs = 6'd0;
    logic saw_full = 1'b0;
    logic slow_rom = 1'b0;
    logic rom_busy = 1'b0;
    logic ram_busy = 1'b0;
    logic [2:0] rom_cnt = 3'd0;
    logic [2:0] ram_cnt = 3'd0;
    logic [31:0] lfsr_state = 32'h043fd7e0;

    main_bus_top #(.FIFO_DEPTH(4)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = !clk;
    end

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [2:0] rand_delay();
        logic [2:0] v;
        for (int b = 0; b < 3; b++) begin
            v[b] = lfsr_bit();
        end
        return v;
    endfunction

    function automatic main_bus_pkg::word_t rom_word(input logic [11:0] ba);
        return {ba[3:0], ba} ^ 16'h6b29;
    endfunction

    function automatic main_bus_pkg::word_t ram_fill(input logic [11:0] ba);
        return {ba[7:0], ba[11:4]} ^ 16'h1234;
    endfunction

    function automatic main_bus_pkg::word_t key_val(input logic [2:0] k);
        return 16'h1f2e ^ {k, 5'd0, k, 5'd0};
    endfunction

    function automatic int region_of(input logic [23:0] a);
        for (int r = 0; r < 5; r++) begin
            if (((a[23:16] ^ cfg_base[r]) & cfg_mask[r]) == 8'h00) begin
                return r;
            end
        end
        return 5;
    endfunction

    // Selects as {rom, ram, vram, char, pal, obj}
    function automatic logic [5:0] cs_of(input logic [23:0] a);
        case (region_of(a))
            0:       return (a[18:17] == 2'b11) ? 6'b010000 : 6'b100000;
            1:       return a[16] ? 6'b000100 : 6'b001000;
            2:       return 6'b000010;
            3:       return 6'b000001;
            default: return 6'b000000;
        endcase
    endfunction

    function automatic main_bus_pkg::byte_t cabinet(input logic [1:0] sel);
        case (sel)
            2'd0:    return JOY1;
            2'd1:    return JOY2;
            2'd2:    return {3'b000, START, COIN, SERV};
            default: return DIPS;
        endcase
    endfunction

    // Expected value for the access with RAM contents tracked in table order
    task automatic add_entry(input logic [23:0] a, input logic rd, input main_bus_pkg::word_t wd,
                             input logic [1:0] ds, input logic op, input logic de,
                             input logic burst);
        logic [11:0] ba;
        logic [5:0] cs;
        main_bus_pkg::word_t k;
        main_bus_pkg::word_t exp;
        ba = a[12:1];
        cs = cs_of(a);
        k = key_val(ba[2:0]);
        exp = 16'hffff;
        if (!rd && (cs == 6'b010000 || cs == 6'b001000)) begin
            exp = (cs == 6'b010000) ? ram_shadow[ba] : vram_shadow[ba];
            if (!ds[1]) exp[15:8] = wd[15:8];
            if (!ds[0]) exp[7:0] = wd[7:0];
            if (cs == 6'b010000) ram_shadow[ba] = exp;
            else vram_shadow[ba] = exp;
        end else if (rd) begin
            case (cs)
                6'b100000: begin
                    exp = rom_word(ba);
                    if (de) exp = exp ^ (op ? k : {k[7:0], k[15:8]});
                end
                6'b010000: exp = ram_shadow[ba];
                6'b001000: exp = vram_shadow[ba];
                6'b000100: exp = {4'hc, ba};
                6'b000010: exp = {4'hb, ba};
                6'b000001: exp = {4'hd, ba};
                default:   exp = (region_of(a) == 4) ? {8'hff, cabinet(a[2:1])} : 16'hffff;
            endcase
        end
        t_addr[n_tests] = a;
        t_rnw[n_tests] = rd;
        t_wdata[n_tests] = wd;
        t_dsn[n_tests] = ds;
        t_op[n_tests] = op;
        t_dec[n_tests] = de;
        t_burst[n_tests] = burst;
        e_rdata[n_tests] = exp;
        e_cs[n_tests] = cs;
        n_tests++;
    endtask

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp, inout logic ok);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            ok = 1'b0;
        end
    endtask

    task automatic abort_run(input string why);
        $display("Timeout at %0t: %s", $time, why);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic wait_free();
        int cnt;
        cnt = 0;
        while (!bus_free) begin
            @(negedge clk);
            cnt++;
            if (cnt > 200) abort_run("bus_free stayed low");
        end
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        while (pending.size() != 0) begin
            @(negedge clk);
            cnt++;
            if (cnt > 1000) abort_run("accesses never completed");
        end
    endtask

    // Memory models with ready after a random delay
    assign rom_data  = rom_word(bus_addr);
    assign ram_data  = vram_cs ? vram_mem[bus_addr] : ram_mem[bus_addr];
    assign char_dout = {4'hc, bus_addr};
    assign pal_dout  = {4'hb, bus_addr};
    assign obj_dout  = {4'hd, bus_addr};

    always @(negedge clk) begin : memory_models
        logic [2:0] d;
        logic fire;
        fire = 1'b0;
        if (!rom_cs) begin
            rom_busy = 1'b0;
            rom_ok = 1'b0;
        end else if (!rom_busy) begin
            d = slow_rom ? 3'd7 : rand_delay();
            rom_busy = 1'b1;
            rom_cnt = d;
            rom_ok = (d == 3'd0);
        end else if (rom_cnt != 3'd0) begin
            rom_cnt = rom_cnt - 3'd1;
            rom_ok = (rom_cnt == 3'd0);
        end
        if (!(ram_cs || vram_cs)) begin
            ram_busy = 1'b0;
            ram_ok = 1'b0;
        end else if (!ram_busy) begin
            d = rand_delay();
            ram_busy = 1'b1;
            ram_cnt = d;
            fire = (d == 3'd0);
        end else if (ram_cnt != 3'd0) begin
            ram_cnt = ram_cnt - 3'd1;
            fire = (ram_cnt == 3'd0);
        end
        // Write lands once as ready rises
        if (fire) begin
            ram_ok = 1'b1;
            if (!bus_rnw && vram_cs) begin
                if (!bus_dsn[1]) vram_mem[bus_addr][15:8] = bus_dout[15:8];
                if (!bus_dsn[0]) vram_mem[bus_addr][7:0] = bus_dout[7:0];
            end else if (!bus_rnw) begin
                if (!bus_dsn[1]) ram_mem[bus_addr][15:8] = bus_dout[15:8];
                if (!bus_dsn[0]) ram_mem[bus_addr][7:0] = bus_dout[7:0];
            end
        end
    end

    always @(negedge clk) begin : done_monitor
        int idx;
        logic ok;
        if (!rst) begin
            seen_cs = seen_cs | {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, obj_cs};
            if (!bus_free) saw_full = 1'b1;
            if (done) done_count++;
            if (done && pending.size() == 0) begin
                $display("Error at %0t: done pulse with no access outstanding", $time);
                errors++;
            end else if (done) begin
                idx = pending.pop_front();
                ok = 1'b1;
                check_value("chip selects", {10'd0, seen_cs}, {10'd0, e_cs[idx]}, ok);
                if (t_rnw[idx]) check_value("rdata", rdata, e_rdata[idx], ok);
                $display("test %0d addr %h %s: %s", idx, t_addr[idx],
                         t_rnw[idx] ? "read" : "write", ok ? "ok" : "mismatch");
                if (ok) pass_count++;
                else fail_count++;
                seen_cs = 6'd0;
            end
        end
    end

    initial begin
        logic ok;
        for (int i = 0; i < 4096; i++) begin
            ram_shadow[i] = ram_fill(12'(i));
            ram_mem[i] = ram_fill(12'(i));
            vram_shadow[i] = ram_fill(12'(i)) ^ 16'h8421;
            vram_mem[i] = ram_fill(12'(i)) ^ 16'h8421;
        end
        rst = 1'b1;
        {req, rnw, op_fetch, cfg_we, key_we, dec_en} = '0;
        addr = '0;
        wdata = '0;
        dsn = 2'b00;
        cfg_addr = '0;
        cfg_data = '0;
        key_addr = '0;
        key_data = '0;
        {rom_ok, ram_ok} = 2'b00;
        joystick1 = JOY1;
        joystick2 = JOY2;
        start_button = START;
        coin_input = COIN;
        service = SERV;
        dipsw = DIPS;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int r = 0; r < 5; r++) begin
            cfg_we = 1'b1;
            cfg_addr = 4'(2 * r);
            cfg_data = cfg_base[r];
            @(negedge clk);
            cfg_addr = 4'(2 * r + 1);
            cfg_data = cfg_mask[r];
            @(negedge clk);
        end
        cfg_we = 1'b0;
        for (int k = 0; k < 8; k++) begin
            key_we = 1'b1;
            key_addr = 3'(k);
            key_data = key_val(3'(k));
            @(negedge clk);
        end
        key_we = 1'b0;

        // addr, read, wdata, dsn, opcode, decrypt, burst
        add_entry(24'h000010, 1, 16'h0000, 2'b00, 0, 0, 0);
        add_entry(24'h060020, 0, 16'hbeef, 2'b00, 0, 0, 0);
        add_entry(24'h060022, 0, 16'h1234, 2'b01, 0, 0, 0);
        add_entry(24'h060020, 1, 16'h0000, 2'b00, 0, 0, 0);
        add_entry(24'h060022, 1, 16'h0000, 2'b00, 0, 0, 0);
        add_entry(24'h400040, 0, 16'ha55a, 2'b10, 0, 0, 0);
        add_entry(24'h400040, 1, 16'h0000, 2'b00, 0, 0, 0);
        add_entry(24'h410008, 1, 16'h0000, 2'b00, 0, 0, 0);
        add_entry(24'h840006, 1, 16'h0000, 2'b00, 0, 0, 0);
        add_entry(24'h440100, 1, 16'h0000, 2'b00, 0, 0, 0);
        add_entry(24'he00000, 1, 16'h0000, 2'b00, 0, 0, 0);
        for (int s = 0; s < 4; s++) begin
            add_entry(24'hc40000 + 24'(2 * s), 1, 16'h0000, 2'b00, 0, 0, 0);
        end
        add_entry(24'h000016, 1, 16'h0000, 2'b00, 1, 1, 0);
        add_entry(24'h00001a, 1, 16'h0000, 2'b00, 0, 1, 0);
        add_entry(24'h020004, 1, 16'h0000, 2'b00, 1, 1, 0);
        for (int b = 0; b < 8; b++) begin
            add_entry(24'h000100 + 24'(2 * b), 1, 16'h0000, 2'b00, 0, 0, 1);
        end

        for (int i = 0; i < n_tests; i++) begin
            if (t_dec[i] != dec_en) begin
                drain();
                dec_en = t_dec[i];
            end
            slow_rom = t_burst[i];
            wait_free();
            req = 1'b1;
            addr = t_addr[i][23:1];
            rnw = t_rnw[i];
            wdata = t_wdata[i];
            dsn = t_dsn[i];
            op_fetch = t_op[i];
            pending.push_back(i);
            @(negedge clk);
            req = 1'b0;
            if (!t_burst[i]) drain();
        end
        drain();

        ok = 1'b1;
        check_value("bus_free low during burst", {15'd0, saw_full}, 16'd1, ok);
        check_value("done count", 16'(done_count), 16'(n_tests), ok);
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 n_tests, pass_count, fail_count, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
